// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

    //////////////////////////////
    // Bus word
    //////////////////////////////
    localparam int word_width = 32;

    typedef logic [word_width-1:0] word_t;

    //////////////////////////////
    // Slaves and address map
    //////////////////////////////
    localparam int slave_count    = 3;
    localparam int slave_ram      = 0;
    localparam int slave_counter  = 1;
    localparam int slave_keyboard = 2;

    // Address bits 15 to 12 pick the slave
    localparam logic [3:0] region_ram      = 4'd0;
    localparam logic [3:0] region_counter  = 4'd1;
    localparam logic [3:0] region_keyboard = 4'd2;

    localparam int ram_words = 1024;

    // Byte offsets of the registers inside a slave
    localparam logic [11:0] reg_data_offset = 12'h000;
    localparam logic [11:0] reg_aux_offset  = 12'h004;

    // Cause codes seen by the CPU
    typedef enum logic [word_width-1:0] {
        cause_none     = 32'd0,
        cause_keyboard = 32'd3,
        cause_counter  = 32'd4
    } irq_cause_t;

endpackage

`default_nettype wire

// File: common/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    // Frame receiver states
    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_parity,
        st_stop
    } ps2_state_t;

    // One keyboard scan code
    typedef logic [7:0] scan_t;

    //////////////////////////////
    // Scan code FIFO sizing
    //////////////////////////////
    localparam int fifo_depth       = 8;
    localparam int fifo_count_width = 4;

endpackage

`default_nettype wire

// File: logic/wb_intercon.sv
`default_nettype none

module wb_intercon import bus_pkg::*; (
    input  word_t                  addr,
    input  logic                   stb,
    output logic                   ack,
    output word_t                  rdata,
    output logic [slave_count-1:0] slave_stb,
    input  logic [slave_count-1:0] slave_ack,
    input  word_t                  slave_rdata_ram,
    input  word_t                  slave_rdata_counter,
    input  word_t                  slave_rdata_keyboard,
    input  logic                   clk,
    input  logic                   arst_n
);

    logic [3:0]             region;
    logic [slave_count-1:0] sel;
    logic                   unmapped;
    logic                   unmapped_ack;

    assign region = addr[15:12];

    // One-hot slave select from the region
    always_comb begin
        sel = '0;
        case (region)
            region_ram:      sel[slave_ram]      = 1'b1;
            region_counter:  sel[slave_counter]  = 1'b1;
            region_keyboard: sel[slave_keyboard] = 1'b1;
            default:         sel = '0;
        endcase
    end

    assign unmapped  = ~|sel;
    assign slave_stb = sel & {slave_count{stb}};

    // Nobody answers here, so ack on behalf of the missing slave
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= stb & unmapped & ~unmapped_ack;
        end
    end

    assign ack = (|(slave_ack & sel)) | unmapped_ack;

    // Read data back from the selected slave, zero when unmapped
    always_comb begin
        case (region)
            region_ram:      rdata = slave_rdata_ram;
            region_counter:  rdata = slave_rdata_counter;
            region_keyboard: rdata = slave_rdata_keyboard;
            default:         rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/bus_ram.sv
`default_nettype none

module bus_ram import bus_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  stb,
    input  logic  we,
    input  word_t addr,
    input  word_t wdata,
    output word_t rdata,
    output logic  ack
);

    word_t      mem [ram_words];
    logic [9:0] index;
    logic       access;

    // Word address
    assign index  = addr[11:2];
    assign access = stb & ~ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    // Array and read register
    always_ff @(posedge clk) begin
        if (access) begin
            if (we) begin
                mem[index] <= wdata;
            end
            rdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

// File: logic/bus_counter.sv
`default_nettype none

module bus_counter import bus_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  stb,
    input  logic  we,
    input  word_t addr,
    input  word_t wdata,
    output word_t rdata,
    output logic  ack,
    output logic  irq
);

    word_t count;
    word_t compare;
    logic  is_data;
    logic  is_aux;
    logic  wr;

    assign is_data = addr[11:0] == reg_data_offset;
    assign is_aux  = addr[11:0] == reg_aux_offset;
    assign wr      = stb & we & ~ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack     <= 1'b0;
            count   <= '0;
            compare <= '0;
            irq     <= 1'b0;
        end else begin
            ack <= stb & ~ack;

            // Load wins over the free-running increment
            if (wr && is_data) begin
                count <= wdata;
            end else begin
                count <= count + 1'b1;
            end

            // Sticky match flag, cleared by a new compare value
            if (wr && is_aux) begin
                compare <= wdata;
                irq     <= 1'b0;
            end else if (count == compare && count != '0) begin
                irq <= 1'b1;
            end
        end
    end

    always_comb begin
        if (is_data) begin
            rdata = count;
        end else if (is_aux) begin
            rdata = compare;
        end else begin
            rdata = '0;
        end
    end

endmodule

`default_nettype wire

// File: keyboard/ps2_receiver.sv
`default_nettype none

module ps2_receiver import ps2_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  ps2_clk,
    input  logic  ps2_data,
    output logic  byte_valid,
    output scan_t byte_data
);

    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       clk_fall;
    logic       frame_ok;
    ps2_state_t state;
    logic [2:0] bit_cnt;
    scan_t      shift;
    logic       parity;

    //////////////////////////////
    // Line synchronisers
    //////////////////////////////

    // Lines idle high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];

    // Stop bit high and odd parity over data plus parity
    assign frame_ok = data_sync[1] & (^{parity, shift});

    //////////////////////////////
    // Frame FSM
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_idle;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (clk_fall) begin
                case (state)
                    st_idle: begin
                        // Wait for a low start bit
                        if (!data_sync[1]) begin
                            state   <= st_data;
                            bit_cnt <= '0;
                        end
                    end
                    st_data: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= st_parity;
                        end
                    end
                    st_parity: state <= st_stop;
                    st_stop: begin
                        byte_valid <= frame_ok;
                        state      <= st_idle;
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            if (state == st_data) begin
                shift <= {data_sync[1], shift[7:1]};
            end
            if (state == st_parity) begin
                parity <= data_sync[1];
            end
            if (state == st_stop) begin
                byte_data <= shift;
            end
        end
    end

endmodule

`default_nettype wire

// File: keyboard/scan_fifo.sv
`default_nettype none

module scan_fifo import ps2_pkg::*; (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        push,
    input  scan_t                       push_data,
    input  logic                        pop,
    output scan_t                       pop_data,
    output logic [fifo_count_width-1:0] count,
    output logic                        empty,
    output logic                        full
);

    scan_t                         mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic                          do_push;
    logic                          do_pop;

    assign empty   = count == '0;
    assign full    = count == fifo_depth[fifo_count_width-1:0];
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // Head entry is visible without a read cycle
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

// File: keyboard/keyboard_port.sv
`default_nettype none

module keyboard_port import bus_pkg::*, ps2_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  stb,
    input  logic  we,
    input  word_t addr,
    output word_t rdata,
    output logic  ack,
    output logic  irq,
    input  logic  ps2_clk,
    input  logic  ps2_data
);

    logic                        byte_valid;
    scan_t                       byte_data;
    logic                        fifo_push;
    logic                        fifo_pop;
    scan_t                       fifo_data;
    logic [fifo_count_width-1:0] fifo_count;
    logic                        fifo_empty;
    logic                        fifo_full;
    logic                        is_data;
    logic                        is_aux;

    ps2_receiver i_ps2_receiver (
        .clk        (clk),
        .arst_n     (arst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    // Overflow bytes are lost
    assign fifo_push = byte_valid & ~fifo_full;

    scan_fifo i_scan_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (fifo_push),
        .push_data (byte_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .count     (fifo_count),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    //////////////////////////////
    // Bus side
    //////////////////////////////
    assign is_data = addr[11:0] == reg_data_offset;
    assign is_aux  = addr[11:0] == reg_aux_offset;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= stb & ~ack;
        end
    end

    // Data read consumes the head entry in its ack cycle
    assign fifo_pop = ack & ~we & is_data & ~fifo_empty;

    always_comb begin
        if (is_data && !fifo_empty) begin
            rdata = {{(word_width-9){1'b0}}, 1'b1, fifo_data};
        end else if (is_aux) begin
            rdata = word_t'(fifo_count);
        end else begin
            rdata = '0;
        end
    end

    assign irq = ~fifo_empty;

endmodule

`default_nettype wire

// File: logic/simple_soc.sv
`default_nettype none

module simple_soc import bus_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       stb,
    input  logic       we,
    input  word_t      addr,
    input  word_t      wdata,
    output word_t      rdata,
    output logic       ack,
    output logic       int_req,
    output irq_cause_t cause,
    input  logic       ps2_clk,
    input  logic       ps2_data
);

    logic [slave_count-1:0] slave_stb;
    logic [slave_count-1:0] slave_ack;
    word_t                  ram_rdata;
    word_t                  counter_rdata;
    word_t                  keyboard_rdata;
    logic                   counter_irq;
    logic                   keyboard_irq;

    //////////////////////////////
    // Bus fabric
    //////////////////////////////
    wb_intercon i_wb_intercon (
        .addr                 (addr),
        .stb                  (stb),
        .ack                  (ack),
        .rdata                (rdata),
        .slave_stb            (slave_stb),
        .slave_ack            (slave_ack),
        .slave_rdata_ram      (ram_rdata),
        .slave_rdata_counter  (counter_rdata),
        .slave_rdata_keyboard (keyboard_rdata),
        .clk                  (clk),
        .arst_n               (arst_n)
    );

    //////////////////////////////
    // Slaves
    //////////////////////////////
    bus_ram i_bus_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .stb    (slave_stb[slave_ram]),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (ram_rdata),
        .ack    (slave_ack[slave_ram])
    );

    bus_counter i_bus_counter (
        .clk    (clk),
        .arst_n (arst_n),
        .stb    (slave_stb[slave_counter]),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (counter_rdata),
        .ack    (slave_ack[slave_counter]),
        .irq    (counter_irq)
    );

    keyboard_port i_keyboard_port (
        .clk      (clk),
        .arst_n   (arst_n),
        .stb      (slave_stb[slave_keyboard]),
        .we       (we),
        .addr     (addr),
        .rdata    (keyboard_rdata),
        .ack      (slave_ack[slave_keyboard]),
        .irq      (keyboard_irq),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data)
    );

    // Keyboard has priority over the counter
    assign int_req = keyboard_irq | counter_irq;
    assign cause   = keyboard_irq ? cause_keyboard :
                     counter_irq  ? cause_counter  :
                                    cause_none;

endmodule

`default_nettype wire

// File: verif/ps2_device.sv
`default_nettype none

module ps2_device import ps2_pkg::*; (
    output logic ps2_clk,
    output logic ps2_data
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int bit_period_ns = 4000;

    // Both lines idle high
    initial begin
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
    end

    // Start, eight data bits LSB first, odd parity, stop
    task automatic send_frame(input scan_t code, input logic bad_parity);
        logic [10:0] frame;
        logic        parity;
        parity = (~^code) ^ bad_parity;
        frame  = {1'b1, parity, code, 1'b0};
        // Every line change lands on a rising system clock edge
        for (int i = 0; i < 11; i++) begin
            ps2_data <= frame[i];
            #(bit_period_ns / 4);
            ps2_clk <= 1'b0;
            #(bit_period_ns / 2);
            ps2_clk <= 1'b1;
            #(bit_period_ns / 4);
        end
    endtask

endmodule

`default_nettype wire

// File: verif/tb_simple_soc.sv
`default_nettype none

module tb_simple_soc import bus_pkg::*, ps2_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period_ns = 20;
    localparam int bit_period_ns = 4000;
    localparam int bus_ops       = 200;
    localparam int frame_count   = 15;
    localparam int watchdog_ns   = 2 * (bus_ops * 4 * clk_period_ns
                                        + frame_count * 11 * bit_period_ns
                                        + 16 * clk_period_ns);

    localparam word_t counter_data    = {16'h0000, region_counter, reg_data_offset};
    localparam word_t counter_compare = {16'h0000, region_counter, reg_aux_offset};
    localparam word_t kbd_data        = {16'h0000, region_keyboard, reg_data_offset};
    localparam word_t kbd_status      = {16'h0000, region_keyboard, reg_aux_offset};
    localparam word_t unmapped_addr   = 32'h0000_5000;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       stb;
    logic       we;
    word_t      addr;
    word_t      wdata;
    word_t      rdata;
    logic       ack;
    logic       int_req;
    irq_cause_t cause;
    logic       ps2_clk;
    logic       ps2_data;

    // Reference model state
    word_t       ref_ram [ram_words];
    word_t       ref_compare;
    scan_t       kbd_q [$];
    logic        counter_pending;
    int          seed = 6654;
    int unsigned cycle_count = 0;

    // Hand-off to the compare process
    string cmp_name;
    word_t cmp_got;
    word_t cmp_exp;
    event  compare_ev;

    word_t       value;
    logic [9:0]  index;
    int unsigned start_cycle;
    int          written [$];

    simple_soc i_simple_soc (
        .clk      (clk),
        .arst_n   (arst_n),
        .stb      (stb),
        .we       (we),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .ack      (ack),
        .int_req  (int_req),
        .cause    (cause),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data)
    );

    ps2_device keyboard_model (
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data)
    );

    always #(clk_period_ns / 2) clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic word_t expected_read(input word_t a);
        word_t result;
        result = '0;
        case (a[15:12])
            region_ram:     result = ref_ram[a[11:2]];
            region_counter: begin
                // Live count is range checked instead
                if (a[11:0] == reg_aux_offset) result = ref_compare;
            end
            region_keyboard: begin
                if (a[11:0] == reg_data_offset && kbd_q.size() > 0) begin
                    result = {23'd0, 1'b1, kbd_q[0]};
                end else if (a[11:0] == reg_aux_offset) begin
                    result = word_t'(kbd_q.size());
                end
            end
            default:        result = '0;
        endcase
        return result;
    endfunction

    // Keyboard before counter
    function automatic irq_cause_t expected_cause();
        irq_cause_t result;
        result = cause_none;
        if (kbd_q.size() > 0) begin
            result = cause_keyboard;
        end else if (counter_pending) begin
            result = cause_counter;
        end
        return result;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_cause(input string name, input irq_cause_t got,
                               input irq_cause_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_with_failure();
        end
    endtask

    always @(compare_ev) begin
        check_word(cmp_name, cmp_got, cmp_exp);
    end

    task automatic check_irq_state();
        irq_cause_t exp;
        @(negedge clk);
        exp = expected_cause();
        check_word("int_req", word_t'(int_req), word_t'(exp != cause_none));
        check_cause("cause", cause, exp);
    endtask

    //////////////////////////////
    // Bus master
    //////////////////////////////
    task automatic bus_cycle(input logic write, input word_t a, input word_t d,
                             output word_t data);
        @(posedge clk);
        stb   <= 1'b1;
        we    <= write;
        addr  <= a;
        wdata <= d;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("Ack arrived in the strobe cycle for address 0x%08h", a);
            stop_with_failure();
        end
        @(negedge clk);
        if (ack !== 1'b1) begin
            $display("No ack one cycle after the strobe for address 0x%08h", a);
            stop_with_failure();
        end
        data = rdata;
        @(posedge clk);
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic bus_write(input word_t a, input word_t d);
        word_t unused;
        bus_cycle(1'b1, a, d, unused);
        if (a[15:12] == region_ram) begin
            ref_ram[a[11:2]] = d;
        end else if (a == counter_compare) begin
            ref_compare = d;
        end
    endtask

    task automatic bus_read(input word_t a, output word_t data);
        bus_cycle(1'b0, a, '0, data);
    endtask

    task automatic read_and_check(input string name, input word_t a);
        word_t exp;
        word_t got;
        exp = expected_read(a);
        bus_read(a, got);
        cmp_name = name;
        cmp_got  = got;
        cmp_exp  = exp;
        -> compare_ev;
        if (a == kbd_data && kbd_q.size() > 0) begin
            kbd_q.delete(0);
        end
    endtask

    task automatic send_frame(input scan_t code, input logic bad_parity);
        @(posedge clk);
        keyboard_model.send_frame(code, bad_parity);
        // FIFO drops anything past its depth
        if (!bad_parity && kbd_q.size() < fifo_depth) begin
            kbd_q.push_back(code);
        end
    endtask

    task automatic wait_int_req(input int limit);
        int waited;
        waited = 0;
        while (int_req !== 1'b1 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (int_req !== 1'b1) begin
            $display("int_req did not rise within %0d cycles", limit);
            stop_with_failure();
        end
    endtask

    // Compare set a little ahead of the running count
    task automatic arm_counter();
        word_t now;
        bus_read(counter_data, now);
        bus_write(counter_compare, now + 32'd20);
        counter_pending = 1'b1;
        wait_int_req(64);
        check_irq_state();
    endtask

    task automatic disarm_counter();
        bus_write(counter_compare, 32'hffff_0000);
        counter_pending = 1'b0;
        check_irq_state();
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns with the tests unfinished", watchdog_ns);
        stop_with_failure();
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        arst_n          = 1'b0;
        stb             = 1'b0;
        we              = 1'b0;
        addr            = '0;
        wdata           = '0;
        ref_compare     = '0;
        counter_pending = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        check_irq_state();

        // RAM
        for (int i = 0; i < 64; i++) begin
            index = $random(seed);
            value = $random(seed);
            bus_write({16'h0000, region_ram, index, 2'b00}, value);
            written.push_back(index);
        end
        foreach (written[i]) begin
            read_and_check("ram rdata", {16'h0000, region_ram, 10'(written[i]), 2'b00});
        end

        read_and_check("unmapped rdata", unmapped_addr);

        // Counter load, compare match and clear
        start_cycle = cycle_count;
        bus_write(counter_data, 32'h0000_1000);
        bus_read(counter_data, value);
        if (value < 32'h1000 || value > 32'h1000 + (cycle_count - start_cycle)) begin
            $display("error: counter rdata 0x%08h outside 0x%08h to 0x%08h",
                     value, 32'h1000, 32'h1000 + (cycle_count - start_cycle));
            stop_with_failure();
        end
        arm_counter();
        read_and_check("counter compare", counter_compare);
        disarm_counter();

        // Three good frames
        send_frame(8'h1c, 1'b0);
        send_frame(8'h32, 1'b0);
        send_frame(8'h21, 1'b0);
        read_and_check("keyboard status", kbd_status);
        repeat (4) read_and_check("keyboard data", kbd_data);

        // Bad parity, then overflow
        send_frame(8'h55, 1'b1);
        read_and_check("keyboard status", kbd_status);
        for (int i = 0; i < 10; i++) begin
            send_frame(8'h10 + 8'(i), 1'b0);
        end
        read_and_check("keyboard status", kbd_status);
        repeat (9) read_and_check("keyboard data", kbd_data);

        // Priority with both sources pending
        arm_counter();
        send_frame(8'h5a, 1'b0);
        check_irq_state();
        read_and_check("keyboard data", kbd_data);
        check_irq_state();
        disarm_counter();

        repeat (2) @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
common/bus_pkg.sv
common/ps2_pkg.sv
logic/wb_intercon.sv
logic/bus_ram.sv
logic/bus_counter.sv
keyboard/ps2_receiver.sv
keyboard/scan_fifo.sv
keyboard/keyboard_port.sv
logic/simple_soc.sv
verif/ps2_device.sv
verif/tb_simple_soc.sv
